// ==== channel_discriminator.sv ====
/*
  One channel of the sample discriminator.
  Holds the channel thresholds, the one-bit hysteresis state, the input word
  timer and the passed-word index. Passed words and run timestamps leave two
  cycles after the word enters.
*/
`timescale 1ns/1ps

module channel_discriminator (
  input  logic                         clk,
  input  logic                         reset,
  input  sample_types_pkg::word_t      word,
  input  logic                         word_valid,
  input  disc_config_pkg::thresholds_t config_in,
  input  logic                         config_valid,
  input  logic                         reset_state,
  output sample_types_pkg::word_t      out_word,
  output logic                         out_valid,
  output disc_config_pkg::timestamp_t  timestamp,
  output logic                         timestamp_valid
);

  disc_config_pkg::thresholds_t thresholds;

  // registered word and decisions from the compare stage
  sample_types_pkg::word_t det_word;
  logic                    det_valid;
  logic                    above_high;
  logic                    below_low;

  // hysteresis state, high while words are being passed
  logic is_high;
  logic next_high;
  logic run_start;

  disc_config_pkg::timer_t        timer;
  disc_config_pkg::sample_index_t sample_index;

  // new thresholds take effect on the word after the config strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      thresholds <= '0;
    end else if (config_valid) begin
      thresholds <= config_in;
    end
  end

  threshold_detect i_threshold_detect (
    .clk          (clk),
    .reset        (reset),
    .word         (word),
    .word_valid   (word_valid),
    .thresholds   (thresholds),
    .word_q       (det_word),
    .word_valid_q (det_valid),
    .above_high   (above_high),
    .below_low    (below_low)
  );

  // a high word wins over the low test, otherwise the state holds
  always_comb begin
    next_high = is_high;
    if (above_high) begin
      next_high = 1'b1;
    end else if (below_low) begin
      next_high = 1'b0;
    end
  end

  assign run_start = above_high && !is_high;

  always_ff @(posedge clk) begin
    if (reset || reset_state) begin
      is_high <= 1'b0;
    end else if (det_valid) begin
      is_high <= next_high;
    end
  end

  // the timer counts every valid word and keeps running through reset_state
  always_ff @(posedge clk) begin
    if (reset) begin
      timer <= '0;
    end else if (det_valid) begin
      timer <= timer + disc_config_pkg::timer_t'(1);
    end
  end

  // index counts passed words, so the timestamp sees the count before this one
  always_ff @(posedge clk) begin
    if (reset || reset_state) begin
      sample_index <= '0;
    end else if (det_valid && next_high) begin
      sample_index <= sample_index + disc_config_pkg::sample_index_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid       <= 1'b0;
      timestamp_valid <= 1'b0;
    end else begin
      out_valid       <= det_valid && next_high;
      timestamp_valid <= det_valid && run_start;
    end
  end

  // payload registers only load when their strobe will be set
  always_ff @(posedge clk) begin
    if (det_valid && next_high) begin
      out_word <= det_word;
    end
    if (det_valid && run_start) begin
      timestamp.timer        <= timer;
      timestamp.sample_index <= sample_index;
    end
  end

endmodule

// ==== disc_config_pkg.sv ====
/*
  Configuration and timestamp types for the sample discriminator.
  Thresholds for all channels arrive together in one config word, and each
  run of passed words is marked by a timestamp of timer and word index.
*/
package disc_config_pkg;

  // width of the passed-word index carried in a timestamp
  localparam int sample_index_width = 14;

  // width of the free running input word counter
  localparam int clock_width = 50;

  typedef logic [sample_index_width-1:0] sample_index_t;
  typedef logic [clock_width-1:0] timer_t;

  // high threshold in the upper half, low threshold in the lower half
  typedef struct packed {
    sample_types_pkg::sample_t high;
    sample_types_pkg::sample_t low;
  } thresholds_t;

  // one threshold pair per channel, channel 0 in the low bits
  typedef struct packed {
    thresholds_t [sample_types_pkg::n_channels-1:0] channel;
  } config_t;

  // timer above the index so a timestamp sorts by arrival time
  typedef struct packed {
    timer_t timer;
    sample_index_t sample_index;
  } timestamp_t;

  typedef struct packed {
    timestamp_t [sample_types_pkg::n_channels-1:0] channel;
  } timestamp_bus_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Builds the sample discriminator testbench with Verilator and runs it.
# The exit status is zero only when the simulation ends without an error.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

verilator --binary --timing --assert \
  --top-module sample_discriminator_tb \
  -Mdir obj_dir \
  -f sample_discriminator.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "compile failed with status $status"
  exit "$status"
fi

if [ ! -x obj_dir/Vsample_discriminator_tb ]; then
  echo "simulation executable is missing"
  exit 1
fi

./obj_dir/Vsample_discriminator_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

echo "simulation finished"
exit 0

// ==== sample_discriminator.f ====
sample_types_pkg.sv
disc_config_pkg.sv
threshold_detect.sv
channel_discriminator.sv
sample_discriminator.sv
sample_discriminator_checker.sv
sample_discriminator_tb.sv

// ==== sample_discriminator.sv ====
/*
  Top level of the multi-channel sample discriminator.
  Splits the data and config buses into channels, runs one discriminator per
  channel and gathers the passed words and timestamps back onto output buses.
*/
`timescale 1ns/1ps

module sample_discriminator (
  input  logic                            clk,
  input  logic                            reset,
  input  sample_types_pkg::data_bus_t     data_in,
  input  sample_types_pkg::chan_vec_t     data_in_valid,
  input  disc_config_pkg::config_t        config_in,
  input  logic                            config_valid,
  input  logic                            reset_state,
  output sample_types_pkg::data_bus_t     data_out,
  output sample_types_pkg::chan_vec_t     data_out_valid,
  output disc_config_pkg::timestamp_bus_t timestamps_out,
  output sample_types_pkg::chan_vec_t     timestamps_valid
);

  // per-channel results, one element per instance
  sample_types_pkg::word_t     chan_word      [sample_types_pkg::n_channels];
  logic                        chan_valid     [sample_types_pkg::n_channels];
  disc_config_pkg::timestamp_t chan_timestamp [sample_types_pkg::n_channels];
  logic                        chan_ts_valid  [sample_types_pkg::n_channels];

  for (genvar ch = 0; ch < sample_types_pkg::n_channels; ch++) begin : g_channel
    channel_discriminator i_channel_discriminator (
      .clk             (clk),
      .reset           (reset),
      .word            (data_in.channel[ch]),
      .word_valid      (data_in_valid[ch]),
      .config_in       (config_in.channel[ch]),
      .config_valid    (config_valid),
      .reset_state     (reset_state),
      .out_word        (chan_word[ch]),
      .out_valid       (chan_valid[ch]),
      .timestamp       (chan_timestamp[ch]),
      .timestamp_valid (chan_ts_valid[ch])
    );
  end

  // pack channel results back onto the output buses
  always_comb begin
    for (int ch = 0; ch < sample_types_pkg::n_channels; ch++) begin
      data_out.channel[ch]       = chan_word[ch];
      data_out_valid[ch]         = chan_valid[ch];
      timestamps_out.channel[ch] = chan_timestamp[ch];
      timestamps_valid[ch]       = chan_ts_valid[ch];
    end
  end

endmodule

// ==== sample_discriminator_checker.sv ====
/*
  Concurrent assertions on the sample discriminator outputs.
  Bound into the top level, it watches reset behavior and the timing of
  the valid strobes in every channel.
*/
`timescale 1ns/1ps

module sample_discriminator_checker (
  input logic                        clk,
  input logic                        reset,
  input sample_types_pkg::chan_vec_t data_in_valid,
  input sample_types_pkg::chan_vec_t data_out_valid,
  input sample_types_pkg::chan_vec_t timestamps_valid
);

  // the output strobes are registered, so they read low one edge into reset
  a_quiet_in_reset : assert property (@(posedge clk)
    reset |=> (data_out_valid == '0 && timestamps_valid == '0))
    else $error("valid output seen while reset is high");

  for (genvar ch = 0; ch < sample_types_pkg::n_channels; ch++) begin : g_channel
    // a timestamp always marks a passed word
    a_stamp_with_word : assert property (@(posedge clk) disable iff (reset)
      timestamps_valid[ch] |-> data_out_valid[ch])
      else $error("timestamp without a passed word on channel %0d", ch);

    // the pipeline is two registers deep
    a_two_cycle_latency : assert property (@(posedge clk) disable iff (reset)
      data_out_valid[ch] |-> $past(data_in_valid[ch], 2))
      else $error("passed word without an input word two cycles before on channel %0d", ch);
  end

endmodule

bind sample_discriminator sample_discriminator_checker i_checker (
  .clk              (clk),
  .reset            (reset),
  .data_in_valid    (data_in_valid),
  .data_out_valid   (data_out_valid),
  .timestamps_valid (timestamps_valid)
);

// ==== sample_discriminator_tb.sv ====
/*
  Testbench for the sample discriminator.
  Applies a table of thresholds and data masks, streams LFSR samples into
  every channel and checks passed words and timestamps against a model.
*/
`timescale 1ns/1ps

module sample_discriminator_tb;

  localparam int n_ch = sample_types_pkg::n_channels;
  localparam int n_rows = 5;
  localparam int drain_limit = 40;
  // a count of all ones leaves that total to the model alone
  localparam logic [15:0] any_count = 16'hffff;

  typedef struct packed {
    disc_config_pkg::config_t cfg;
    logic [n_ch-1:0][15:0]    mask;
    logic [15:0]              n_words;
    logic [n_ch-1:0][15:0]    want_stamps;
    logic [n_ch-1:0][15:0]    want_words;
    logic                     reset_after;
  } row_t;

  typedef struct packed {
    logic [31:0]             cycle;
    sample_types_pkg::word_t word;
  } exp_word_t;

  typedef struct packed {
    logic [31:0]                 cycle;
    disc_config_pkg::timestamp_t stamp;
  } exp_stamp_t;

  logic                            clk;
  logic                            reset;
  sample_types_pkg::data_bus_t     data_in;
  sample_types_pkg::chan_vec_t     data_in_valid;
  disc_config_pkg::config_t        config_in;
  logic                            config_valid;
  logic                            reset_state;
  sample_types_pkg::data_bus_t     data_out;
  sample_types_pkg::chan_vec_t     data_out_valid;
  disc_config_pkg::timestamp_bus_t timestamps_out;
  sample_types_pkg::chan_vec_t     timestamps_valid;

  logic [31:0] cycle_count = '0;
  logic [31:0] lfsr_state;
  row_t        rows [n_rows];

  // reference model state with one entry per channel
  logic                           model_high  [n_ch];
  disc_config_pkg::timer_t        model_timer [n_ch];
  disc_config_pkg::sample_index_t model_index [n_ch];

  exp_word_t   exp_words   [n_ch][$];
  exp_stamp_t  exp_stamps  [n_ch][$];
  logic [15:0] words_seen  [n_ch] = '{default: '0};
  logic [15:0] stamps_seen [n_ch] = '{default: '0};

  sample_discriminator i_sample_discriminator (
    .clk              (clk),
    .reset            (reset),
    .data_in          (data_in),
    .data_in_valid    (data_in_valid),
    .config_in        (config_in),
    .config_valid     (config_valid),
    .reset_state      (reset_state),
    .data_out         (data_out),
    .data_out_valid   (data_out_valid),
    .timestamps_out   (timestamps_out),
    .timestamps_valid (timestamps_valid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 32'd1;
  end

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      stop_with_error($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                                $time, name, actual, expected));
    end
  endtask

  // galois form of x^32 + x^22 + x^2 + x + 1
  // the bit taken is the one shifted out
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) next = next ^ 32'h8020_0003;
    return next;
  endfunction

  function automatic disc_config_pkg::thresholds_t threshold_pair(
      input sample_types_pkg::sample_t low, input sample_types_pkg::sample_t high);
    disc_config_pkg::thresholds_t t;
    t.low  = low;
    t.high = high;
    return t;
  endfunction

  function automatic row_t make_row(
      input disc_config_pkg::thresholds_t t0, input logic [15:0] m0,
      input disc_config_pkg::thresholds_t t1, input logic [15:0] m1,
      input logic [15:0] n_words, input logic [15:0] s0, input logic [15:0] s1,
      input logic [15:0] w0, input logic [15:0] w1, input logic reset_after);
    row_t r;
    r.cfg.channel[0] = t0;
    r.cfg.channel[1] = t1;
    r.mask[0]        = m0;
    r.mask[1]        = m1;
    r.n_words        = n_words;
    r.want_stamps[0] = s0;
    r.want_stamps[1] = s1;
    r.want_words[0]  = w0;
    r.want_words[1]  = w1;
    r.reset_after    = reset_after;
    return r;
  endfunction

  // the 8403 mask mixes negative, small and just-above-1024 samples
  task automatic fill_table();
    rows[0] = make_row(threshold_pair(16'h0000, 16'h0000), 16'h7fff,
                       threshold_pair(16'h0000, 16'h0000), 16'h7fff,
                       16'd40, 16'd1, 16'd1, any_count, any_count, 1'b0);
    rows[1] = make_row(threshold_pair(16'h7000, 16'h7fff), 16'h0fff,
                       threshold_pair(16'h7000, 16'h7fff), 16'h0fff,
                       16'd40, 16'd0, 16'd0, 16'd0, 16'd0, 1'b1);
    rows[2] = make_row(threshold_pair(16'h03c0, 16'h0400), 16'h8403,
                       threshold_pair(16'h03c0, 16'h0400), 16'h8403,
                       16'd200, any_count, any_count, any_count, any_count, 1'b0);
    rows[3] = make_row(threshold_pair(16'h03c0, 16'h0400), 16'h8403,
                       threshold_pair(16'h1000, 16'h2000), 16'h7fff,
                       16'd120, any_count, any_count, any_count, any_count, 1'b1);
    rows[4] = make_row(threshold_pair(16'h03c0, 16'h0400), 16'h8403,
                       threshold_pair(16'h03c0, 16'h0400), 16'h8403,
                       16'd60, any_count, any_count, any_count, any_count, 1'b0);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic draw_sample(input logic [15:0] mask, output sample_types_pkg::sample_t s);
    logic [15:0] bits;
    for (int b = 0; b < sample_types_pkg::sample_width; b++) begin
      bits[b]    = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    s = bits & mask;
  endtask

  // hysteresis rule applied to one valid word, in arrival order
  task automatic model_word(input int ch, input sample_types_pkg::word_t w,
                            input disc_config_pkg::thresholds_t th,
                            input logic [31:0] out_cycle);
    logic       any_above;
    logic       all_below;
    exp_word_t  ew;
    exp_stamp_t es;
    any_above = 1'b0;
    all_below = 1'b1;
    for (int i = 0; i < sample_types_pkg::parallel_samples; i++) begin
      if ($signed(w[i]) > $signed(th.high)) any_above = 1'b1;
      if (!($signed(w[i]) < $signed(th.low))) all_below = 1'b0;
    end
    if (any_above) begin
      if (!model_high[ch]) begin
        es.cycle              = out_cycle;
        es.stamp.timer        = model_timer[ch];
        es.stamp.sample_index = model_index[ch];
        exp_stamps[ch].push_back(es);
      end
      model_high[ch] = 1'b1;
    end else if (all_below) begin
      model_high[ch] = 1'b0;
    end
    if (model_high[ch]) begin
      ew.cycle = out_cycle;
      ew.word  = w;
      exp_words[ch].push_back(ew);
      model_index[ch] = model_index[ch] + disc_config_pkg::sample_index_t'(1);
    end
    model_timer[ch] = model_timer[ch] + disc_config_pkg::timer_t'(1);
  endtask

  function automatic logic queues_empty();
    logic empty;
    empty = 1'b1;
    for (int ch = 0; ch < n_ch; ch++) begin
      if (exp_words[ch].size() != 0 || exp_stamps[ch].size() != 0) empty = 1'b0;
    end
    return empty;
  endfunction

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (!queues_empty() && waited < drain_limit) begin
      next_cycle();
      waited++;
    end
    if (!queues_empty()) begin
      stop_with_error($sformatf("timeout: expected outputs still pending after %0d cycles",
                                drain_limit));
    end
  endtask

  task automatic run_row(input row_t row);
    sample_types_pkg::word_t   w;
    sample_types_pkg::sample_t s;
    logic [15:0]               words_start  [n_ch];
    logic [15:0]               stamps_start [n_ch];
    for (int ch = 0; ch < n_ch; ch++) begin
      words_start[ch]  = words_seen[ch];
      stamps_start[ch] = stamps_seen[ch];
    end
    config_in    = row.cfg;
    config_valid = 1'b1;
    next_cycle();
    config_valid = 1'b0;
    for (int k = 0; k < int'(row.n_words); k++) begin
      for (int ch = 0; ch < n_ch; ch++) begin
        for (int i = 0; i < sample_types_pkg::parallel_samples; i++) begin
          draw_sample(row.mask[ch], s);
          w[i] = s;
        end
        data_in.channel[ch] = w;
        model_word(ch, w, row.cfg.channel[ch], cycle_count + 32'd2);
      end
      data_in_valid = '1;
      next_cycle();
    end
    data_in_valid = '0;
    // the last two words are still inside the two-stage pipeline
    repeat (2) next_cycle();
    wait_drained();
    for (int ch = 0; ch < n_ch; ch++) begin
      if (row.want_stamps[ch] != any_count) begin
        check_value($sformatf("timestamp count of channel %0d", ch),
                    64'(stamps_seen[ch] - stamps_start[ch]), 64'(row.want_stamps[ch]));
      end
      if (row.want_words[ch] != any_count) begin
        check_value($sformatf("word count of channel %0d", ch),
                    64'(words_seen[ch] - words_start[ch]), 64'(row.want_words[ch]));
      end
    end
  endtask

  // data stays idle for three cycles on both sides of the pulse
  task automatic pulse_reset_state();
    repeat (3) next_cycle();
    reset_state = 1'b1;
    next_cycle();
    reset_state = 1'b0;
    for (int ch = 0; ch < n_ch; ch++) begin
      model_high[ch]  = 1'b0;
      model_index[ch] = '0;
    end
    repeat (3) next_cycle();
  endtask

  // outputs are compared at the falling edge half a cycle after they change
  always @(negedge clk) begin : watch_outputs
    exp_word_t  ew;
    exp_stamp_t es;
    for (int ch = 0; ch < n_ch; ch++) begin
      if (data_out_valid[ch]) begin
        if (exp_words[ch].size() == 0) begin
          stop_with_error($sformatf("channel %0d passed a word that was not expected at %0t",
                                    ch, $time));
        end else begin
          ew = exp_words[ch].pop_front();
          check_value($sformatf("data_out_valid[%0d] cycle", ch), 64'(cycle_count),
                      64'(ew.cycle));
          check_value($sformatf("data_out.channel[%0d]", ch), data_out.channel[ch], ew.word);
          words_seen[ch] = words_seen[ch] + 16'd1;
        end
      end else if (exp_words[ch].size() != 0 && exp_words[ch][0].cycle <= cycle_count) begin
        stop_with_error($sformatf("channel %0d did not pass an expected word at %0t",
                                  ch, $time));
      end
      if (timestamps_valid[ch]) begin
        if (exp_stamps[ch].size() == 0) begin
          stop_with_error($sformatf("channel %0d gave a timestamp that was not expected at %0t",
                                    ch, $time));
        end else begin
          es = exp_stamps[ch].pop_front();
          check_value($sformatf("timestamps_valid[%0d] cycle", ch), 64'(cycle_count),
                      64'(es.cycle));
          check_value($sformatf("timestamps_out.channel[%0d]", ch),
                      timestamps_out.channel[ch], es.stamp);
          stamps_seen[ch] = stamps_seen[ch] + 16'd1;
        end
      end else if (exp_stamps[ch].size() != 0 && exp_stamps[ch][0].cycle <= cycle_count) begin
        stop_with_error($sformatf("channel %0d did not give an expected timestamp at %0t",
                                  ch, $time));
      end
    end
  end

  initial begin : main
    reset         = 1'b1;
    data_in       = '0;
    data_in_valid = '0;
    config_in     = '0;
    config_valid  = 1'b0;
    reset_state   = 1'b0;
    lfsr_state    = 32'h3d27;
    for (int ch = 0; ch < n_ch; ch++) begin
      model_high[ch]  = 1'b0;
      model_timer[ch] = '0;
      model_index[ch] = '0;
    end
    fill_table();
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    next_cycle();
    for (int r = 0; r < n_rows; r++) begin
      run_row(rows[r]);
      if (rows[r].reset_after) pulse_reset_state();
    end
    if (queues_empty()) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_with_error("expected outputs were still pending at the end of the run");
    end
  end

endmodule

// ==== sample_types_pkg.sv ====
/*
  Data path types for the sample discriminator.
  Each channel carries words of parallel signed samples, and the bus types
  gather one word per channel for the top level ports.
*/
package sample_types_pkg;

  // number of independent discriminator channels
  localparam int n_channels = 2;

  // bits in one ADC sample
  localparam int sample_width = 16;

  // samples delivered side by side in each word
  localparam int parallel_samples = 4;

  // one signed sample as it arrives from the converter
  typedef logic signed [sample_width-1:0] sample_t;

  // sample 0 sits in the low bits of the word and is the oldest in time
  typedef sample_t [parallel_samples-1:0] word_t;

  // one strobe bit per channel, bit 0 belongs to channel 0
  typedef logic [n_channels-1:0] chan_vec_t;

  // all channel words in one bus
  // channel 0 occupies the low word so the layout matches chan_vec_t
  typedef struct packed {
    word_t [n_channels-1:0] channel;
  } data_bus_t;

endpackage

// ==== threshold_detect.sv ====
/*
  Threshold comparison stage for one channel.
  Compares every sample of an incoming word against the high and low
  thresholds and registers the reduced decisions next to the word, so the
  hysteresis logic sees a word and its decisions in the same cycle.
*/
`timescale 1ns/1ps

module threshold_detect (
  input  logic                        clk,
  input  logic                        reset,
  input  sample_types_pkg::word_t     word,
  input  logic                        word_valid,
  input  disc_config_pkg::thresholds_t thresholds,
  output sample_types_pkg::word_t     word_q,
  output logic                        word_valid_q,
  output logic                        above_high,
  output logic                        below_low
);

  // per-sample comparison results before reduction
  logic [sample_types_pkg::parallel_samples-1:0] sample_above;
  logic [sample_types_pkg::parallel_samples-1:0] sample_below;

  // all comparisons are signed, so negative samples sit below a zero threshold
  always_comb begin
    for (int i = 0; i < sample_types_pkg::parallel_samples; i++) begin
      sample_above[i] = $signed(word[i]) > $signed(thresholds.high);
      sample_below[i] = $signed(word[i]) < $signed(thresholds.low);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      word_valid_q <= 1'b0;
    end else begin
      word_valid_q <= word_valid;
    end
  end

  // a single sample over the high threshold is enough to start a run
  // but every sample must drop under the low threshold to end it
  always_ff @(posedge clk) begin
    word_q     <= word;
    above_high <= |sample_above;
    below_low  <= &sample_below;
  end

endmodule
